// File: flist.f
+incdir+verilog
verilog/cgra_cfg_pkg.sv
verilog/cgra_data_pkg.sv
verilog/stream_fifo.sv
verilog/stream_reader.sv
verilog/cgra_control_exec.sv
verilog/cgra_pe.sv
verilog/cgra_pe_array.sv
verilog/stream_writer.sv
verilog/cgra_top.sv
sim/cgra_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cgra_tb -f flist.f -o cgra_sim \
  || { echo "build error"; exit 1; }
./obj_dir/cgra_sim | tee /dev/stderr | grep "All checks passed" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim/cgra_tb.sv
`timescale 1ns/1ps
`include "cgra_defs.svh"

module cgra_tb;

  localparam int nch         = `CGRA_NUM_CH;
  localparam int npe         = `CGRA_NUM_PE;
  localparam int depth       = `CGRA_FIFO_DEPTH;
  localparam int aw          = $clog2(`CGRA_NUM_PE);
  localparam int lw          = `CGRA_LEN_W;
  localparam int len_full    = 12;
  localparam int len_wmask   = 10;
  localparam int len_slow    = 16;
  localparam int len_rmask   = 8;
  localparam int len_restart = 12;
  localparam int total_words = len_full + len_wmask + len_slow + len_rmask + len_restart;
  localparam int max_cycles  = 40 * total_words + 500;

  logic                    clk;
  logic                    rst;
  cgra_data_pkg::ch_mask_t in_push;
  cgra_data_pkg::data_t    in_data [nch];
  cgra_data_pkg::ch_mask_t in_full;
  logic                    cfg_we;
  logic [aw-1:0]           cfg_addr;
  cgra_cfg_pkg::pe_op_t    cfg_op;
  cgra_data_pkg::data_t    cfg_const;
  logic                    start;
  cgra_data_pkg::ch_mask_t read_mask;
  cgra_data_pkg::ch_mask_t write_mask;
  logic [lw-1:0]           stream_len;
  cgra_data_pkg::ch_mask_t out_pop;
  cgra_data_pkg::data_t    out_data [nch];
  cgra_data_pkg::ch_mask_t out_empty;
  logic                    done;

  int                      seed;
  int                      value_errs;
  int                      other_errs;
  int                      cycles;
  bit                      slow_pop;
  cgra_cfg_pkg::pe_op_t    pe_op [npe];
  cgra_data_pkg::data_t    pe_const [npe];
  cgra_data_pkg::data_t    in_q [nch][$];   // host copy of each input queue.
  cgra_data_pkg::data_t    exp_q [nch][$];

  cgra_top dut0 (
    .clk (clk), .rst (rst),
    .in_push (in_push), .in_data (in_data), .in_full (in_full),
    .cfg_we (cfg_we), .cfg_addr (cfg_addr), .cfg_op (cfg_op), .cfg_const (cfg_const),
    .start (start), .read_mask (read_mask), .write_mask (write_mask),
    .stream_len (stream_len), .out_pop (out_pop), .out_data (out_data),
    .out_empty (out_empty), .done (done)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic cgra_data_pkg::data_t alu_ref(input cgra_cfg_pkg::pe_op_t op,
                                                   input cgra_data_pkg::data_t a,
                                                   input cgra_data_pkg::data_t b);
    case (op)
      cgra_cfg_pkg::op_add:     return a + b;
      cgra_cfg_pkg::op_sub:     return a - b;
      cgra_cfg_pkg::op_xor:     return a ^ b;
      cgra_cfg_pkg::op_mul_low: return a * b;
      default:                  return a;
    endcase
  endfunction

  function automatic cgra_data_pkg::data_t expected_word(input int ch,
                                                         input cgra_data_pkg::data_t x0,
                                                         input cgra_data_pkg::data_t x1);
    cgra_data_pkg::data_t s0;
    if (ch == 0) begin
      s0 = alu_ref(pe_op[0], x0, x1);
    end else begin
      s0 = alu_ref(pe_op[1], x1, x0);  // lane 1 takes its own word as a.
    end
    return alu_ref(pe_op[nch + ch], s0, pe_const[nch + ch]);
  endfunction

  // --------------------------------------------------
  // host tasks
  // --------------------------------------------------
  task automatic configure_array();
    logic [31:0] r;
    for (int p = 0; p < npe; p++) begin
      @(negedge clk);
      r           = $random(seed);
      pe_op[p]    = cgra_cfg_pkg::pe_op_t'(r[2:0] % 3'd5);
      pe_const[p] = r[31:16];
      cfg_we      = 1'b1;
      cfg_addr    = aw'(p);
      cfg_op      = pe_op[p];
      cfg_const   = pe_const[p];
    end
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic push_words(input int n, input cgra_data_pkg::ch_mask_t mask);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      for (int c = 0; c < nch; c++) begin
        r          = $random(seed);
        in_push[c] = mask[c] && (in_q[c].size() < depth);  // never push into a full queue.
        in_data[c] = r[15:0];
        if (in_push[c]) begin
          in_q[c].push_back(r[15:0]);
        end
      end
    end
    @(negedge clk);
    in_push = '0;
    for (int c = 0; c < nch; c++) begin
      assert (in_full[c] == (in_q[c].size() == depth)) else begin
        value_errs++;
        $display("FAILED t=%0t in_full[%0d] expected %b actual %b",
                 $time, c, in_q[c].size() == depth, in_full[c]);
      end
    end
  endtask

  task automatic run_stream(input int len, input cgra_data_pkg::ch_mask_t rmask,
                            input cgra_data_pkg::ch_mask_t wmask, input bit hold_full);
    cgra_data_pkg::data_t x0;
    cgra_data_pkg::data_t x1;
    @(negedge clk);
    read_mask  = rmask;
    write_mask = wmask;
    stream_len = lw'(len);
    for (int i = 0; i < len; i++) begin
      x0 = '0;
      x1 = '0;
      if (rmask[0]) begin
        x0 = in_q[0].pop_front();
      end
      if (rmask[1]) begin
        x1 = in_q[1].pop_front();
      end
      for (int c = 0; c < nch; c++) begin
        if (wmask[c]) begin
          exp_q[c].push_back(expected_word(c, x0, x1));
        end
      end
    end
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    assert (done == 1'b0) else begin
      value_errs++;
      $display("FAILED t=%0t done expected 0 actual %b", $time, done);
    end
    while (done !== 1'b1) begin
      @(negedge clk);
      if (hold_full) begin
        assert (in_full[1] == 1'b1) else begin
          value_errs++;
          $display("FAILED t=%0t in_full[1] expected 1 actual %b", $time, in_full[1]);
        end
      end
    end
    while (exp_q[0].size() + exp_q[1].size() > 0) begin
      @(negedge clk);
      assert (done == 1'b1) else begin
        value_errs++;
        $display("FAILED t=%0t done expected 1 actual %b", $time, done);
      end
    end
    repeat (3) begin
      @(negedge clk);
      assert (done == 1'b1 && out_empty == '1) else begin
        value_errs++;
        $display("FAILED t=%0t done/out_empty expected 1/11 actual %b/%b",
                 $time, done, out_empty);
      end
    end
  endtask

  // --------------------------------------------------
  // output compare
  // --------------------------------------------------
  initial begin
    cgra_data_pkg::ch_mask_t pop_now;
    cgra_data_pkg::data_t    expect_val;
    logic [31:0]             r;
    bit                      take;
    out_pop = '0;
    forever begin
      @(negedge clk);
      pop_now = '0;
      for (int c = 0; c < nch; c++) begin
        take = 1'b0;
        if (!rst && !out_empty[c]) begin
          take = 1'b1;
          if (slow_pop) begin
            r    = $random(seed);
            take = (r[2:0] == 3'd0);  // long gaps between pops.
          end
        end
        if (take) begin
          pop_now[c] = 1'b1;
          assert (exp_q[c].size() > 0) else begin
            other_errs++;
            $display("extra word %h on output channel %0d at %0t", out_data[c], c, $time);
          end
          if (exp_q[c].size() > 0) begin
            expect_val = exp_q[c].pop_front();
            assert (out_data[c] == expect_val) else begin
              value_errs++;
              $display("FAILED t=%0t out_data[%0d] expected %h actual %h",
                       $time, c, expect_val, out_data[c]);
            end
          end
        end
      end
      out_pop = pop_now;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("Checks failed");
    $finish;
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    seed       = 80921;
    value_errs = 0;
    other_errs = 0;
    slow_pop   = 1'b0;
    clk        = 1'b0;
    rst        = 1'b1;
    in_push    = '0;
    in_data    = '{default: '0};
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_op     = cgra_cfg_pkg::op_add;
    cfg_const  = '0;
    start      = 1'b0;
    read_mask  = '1;
    write_mask = '1;
    stream_len = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    configure_array();
    push_words(len_full, '1);
    repeat (4) begin
      @(negedge clk);
      assert (done == 1'b0 && out_empty == '1) else begin
        value_errs++;
        $display("FAILED t=%0t done/out_empty expected 0/11 actual %b/%b",
                 $time, done, out_empty);
      end
    end
    run_stream(len_full, '1, '1, 1'b0);

    push_words(len_wmask, '1);
    run_stream(len_wmask, 2'b11, 2'b01, 1'b0);  // queue 1 gets nothing.

    push_words(len_slow, '1);
    slow_pop = 1'b1;
    run_stream(len_slow, '1, '1, 1'b0);
    slow_pop = 1'b0;

    push_words(len_rmask, 2'b01);
    push_words(depth, 2'b10);  // fills queue 1, which stays untouched.
    run_stream(len_rmask, 2'b01, '1, 1'b1);

    configure_array();
    push_words(len_restart, 2'b01);
    run_stream(len_restart, '1, '1, 1'b0);

    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verilog/cgra_top.sv
`timescale 1ns/1ps
`include "cgra_defs.svh"

module cgra_top (
  input  logic                            clk,
  input  logic                            rst,
  input  cgra_data_pkg::ch_mask_t         in_push,
  input  cgra_data_pkg::data_t            in_data [`CGRA_NUM_CH],
  output cgra_data_pkg::ch_mask_t         in_full,
  input  logic                            cfg_we,
  input  logic [$clog2(`CGRA_NUM_PE)-1:0] cfg_addr,
  input  cgra_cfg_pkg::pe_op_t            cfg_op,
  input  cgra_data_pkg::data_t            cfg_const,
  input  logic                            start,
  input  cgra_data_pkg::ch_mask_t         read_mask,
  input  cgra_data_pkg::ch_mask_t         write_mask,
  input  logic [`CGRA_LEN_W-1:0]          stream_len,
  input  cgra_data_pkg::ch_mask_t         out_pop,
  output cgra_data_pkg::data_t            out_data [`CGRA_NUM_CH],
  output cgra_data_pkg::ch_mask_t         out_empty,
  output logic                            done
);

  cgra_data_pkg::ch_mask_t available_pop;
  cgra_data_pkg::ch_mask_t available_read;
  cgra_data_pkg::ch_mask_t read_fifo_done;
  cgra_data_pkg::ch_mask_t available_push;
  cgra_data_pkg::ch_mask_t available_write;
  cgra_data_pkg::ch_mask_t write_fifo_done;
  logic [`CGRA_NUM_PE-1:0] en_pe;
  logic [`CGRA_NUM_CH-1:0] en_net;
  logic                    en_fetch;
  cgra_data_pkg::token_t   rd_token [`CGRA_NUM_CH];
  cgra_data_pkg::token_t   wr_token [`CGRA_NUM_CH];

  stream_reader u_reader (
    .clk (clk), .rst (rst),
    .in_push (in_push), .in_data (in_data), .in_full (in_full),
    .en_fetch (en_fetch), .read_mask (read_mask), .stream_len (stream_len),
    .write_ready (available_push), .start (start),
    .available_pop (available_pop), .available_read (available_read),
    .read_fifo_done (read_fifo_done), .rd_token (rd_token)
  );

  cgra_control_exec u_ctrl (
    .clk (clk), .rst (rst), .start (start),
    .read_mask (read_mask), .write_mask (write_mask),
    .available_read (available_read), .available_write (available_write),
    .available_pop (available_pop), .available_push (available_push),
    .read_fifo_done (read_fifo_done), .write_fifo_done (write_fifo_done),
    .en_pe (en_pe), .en_net (en_net), .en_fetch (en_fetch), .done (done)
  );

  cgra_pe_array u_array (
    .clk (clk), .rst (rst),
    .cfg_we (cfg_we), .cfg_addr (cfg_addr), .cfg_op (cfg_op), .cfg_const (cfg_const),
    .en_pe (en_pe), .en_net (en_net),
    .rd_token (rd_token), .wr_token (wr_token)
  );

  stream_writer u_writer (
    .clk (clk), .rst (rst),
    .wr_token (wr_token), .en_step (en_pe[`CGRA_NUM_PE-1]),
    .write_mask (write_mask), .stream_len (stream_len), .start (start),
    .out_pop (out_pop), .out_data (out_data), .out_empty (out_empty),
    .available_write (available_write), .available_push (available_push),
    .write_fifo_done (write_fifo_done)
  );

endmodule

// File: verilog/stream_writer.sv
`timescale 1ns/1ps
`include "cgra_defs.svh"

module stream_writer (
  input  logic                    clk,
  input  logic                    rst,
  input  cgra_data_pkg::token_t   wr_token [`CGRA_NUM_CH],
  input  logic                    en_step,
  input  cgra_data_pkg::ch_mask_t write_mask,
  input  logic [`CGRA_LEN_W-1:0]  stream_len,
  input  logic                    start,
  input  cgra_data_pkg::ch_mask_t out_pop,
  output cgra_data_pkg::data_t    out_data [`CGRA_NUM_CH],
  output cgra_data_pkg::ch_mask_t out_empty,
  output cgra_data_pkg::ch_mask_t available_write,
  output cgra_data_pkg::ch_mask_t available_push,
  output cgra_data_pkg::ch_mask_t write_fifo_done
);

  localparam int nch = `CGRA_NUM_CH;
  localparam int fw  = $clog2(`CGRA_FIFO_DEPTH + 1);

  logic                    en_q;
  cgra_data_pkg::ch_mask_t push;
  cgra_data_pkg::ch_mask_t full;
  logic [fw-1:0]           free_cnt [nch];
  logic [`CGRA_LEN_W-1:0]  wr_cnt [nch];

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q <= 1'b0;
    end else begin
      en_q <= en_step;  // output token is fresh one cycle after its step.
    end
  end

  assign available_write = ~full;

  for (genvar c = 0; c < nch; c++) begin : g_ch
    // drain tokens past the stream length are discarded.
    assign push[c] = en_q & wr_token[c].valid & write_mask[c] & ~write_fifo_done[c];
    assign available_push[c]  = ~write_mask[c] | (free_cnt[c] >= fw'(`CGRA_PUSH_MARGIN));
    assign write_fifo_done[c] = (wr_cnt[c] == stream_len);

    stream_fifo #(
      .payload_t (cgra_data_pkg::data_t),
      .depth     (`CGRA_FIFO_DEPTH)
    ) u_out_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (push[c]),
      .push_data (wr_token[c].data),
      .pop       (out_pop[c]),
      .head      (out_data[c]),
      .empty     (out_empty[c]),
      .full      (full[c]),
      .free_cnt  (free_cnt[c])
    );

    always_ff @(posedge clk) begin
      if (rst || start) begin
        wr_cnt[c] <= '0;
      end else if (push[c]) begin
        wr_cnt[c] <= wr_cnt[c] + 1'b1;
      end
    end
  end

endmodule

// File: verilog/cgra_pe_array.sv
`timescale 1ns/1ps
`include "cgra_defs.svh"

module cgra_pe_array (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            cfg_we,
  input  logic [$clog2(`CGRA_NUM_PE)-1:0] cfg_addr,
  input  cgra_cfg_pkg::pe_op_t            cfg_op,
  input  cgra_data_pkg::data_t            cfg_const,
  input  logic [`CGRA_NUM_PE-1:0]         en_pe,
  input  logic [`CGRA_NUM_CH-1:0]         en_net,
  input  cgra_data_pkg::token_t           rd_token [`CGRA_NUM_CH],
  output cgra_data_pkg::token_t           wr_token [`CGRA_NUM_CH]
);

  localparam int nch = `CGRA_NUM_CH;
  localparam int npe = `CGRA_NUM_PE;
  localparam int aw  = $clog2(`CGRA_NUM_PE);

  cgra_cfg_pkg::pe_cfg_t cfg;
  logic [npe-1:0]        pe_we;
  cgra_data_pkg::token_t s0_y [nch];
  cgra_data_pkg::data_t  const_q [nch];
  cgra_data_pkg::token_t net_b [nch];

  assign cfg = '{op: cfg_op, value: cfg_const};

  for (genvar i = 0; i < npe; i++) begin : g_we
    assign pe_we[i] = cfg_we && (cfg_addr == aw'(i));
  end

  // --------------------------------------------------
  // stage 0 crosses the lanes, stage 1 adds the constant
  // --------------------------------------------------
  for (genvar i = 0; i < nch; i++) begin : g_lane
    cgra_pe u_s0 (
      .clk    (clk),
      .rst    (rst),
      .cfg_we (pe_we[i]),
      .cfg    (cfg),
      .en     (en_pe[i]),
      .a      (rd_token[i]),
      .b      (rd_token[nch-1-i]),
      .y      (s0_y[i])
    );

    always_ff @(posedge clk) begin
      if (pe_we[nch+i]) begin
        const_q[i] <= cfg_const;
      end
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        net_b[i] <= '0;
      end else if (en_net[i]) begin
        net_b[i] <= '{data: const_q[i], valid: 1'b1};
      end
    end

    cgra_pe u_s1 (
      .clk    (clk),
      .rst    (rst),
      .cfg_we (pe_we[nch+i]),
      .cfg    (cfg),
      .en     (en_pe[nch+i]),
      .a      (s0_y[i]),
      .b      (net_b[i]),
      .y      (wr_token[i])
    );
  end

endmodule

// File: verilog/cgra_pe.sv
`timescale 1ns/1ps

module cgra_pe (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cfg_we,
  input  cgra_cfg_pkg::pe_cfg_t  cfg,
  input  logic                   en,
  input  cgra_data_pkg::token_t  a,
  input  cgra_data_pkg::token_t  b,
  output cgra_data_pkg::token_t  y
);

  cgra_cfg_pkg::pe_op_t op_q;
  cgra_data_pkg::data_t alu;

  always_ff @(posedge clk) begin
    if (rst) begin
      op_q <= cgra_cfg_pkg::op_pass_a;
    end else if (cfg_we) begin
      op_q <= cfg.op;  // constant is held by the array.
    end
  end

  always_comb begin
    case (op_q)
      cgra_cfg_pkg::op_add:     alu = a.data + b.data;
      cgra_cfg_pkg::op_sub:     alu = a.data - b.data;
      cgra_cfg_pkg::op_xor:     alu = a.data ^ b.data;
      cgra_cfg_pkg::op_mul_low: alu = a.data * b.data;
      default:                  alu = a.data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      y <= '0;
    end else if (en) begin
      y <= '{data: alu, valid: a.valid & b.valid};
    end
  end

endmodule

// File: verilog/cgra_control_exec.sv
`timescale 1ns/1ps
`include "cgra_defs.svh"

module cgra_control_exec (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  cgra_data_pkg::ch_mask_t  read_mask,
  input  cgra_data_pkg::ch_mask_t  write_mask,
  input  cgra_data_pkg::ch_mask_t  available_read,
  input  cgra_data_pkg::ch_mask_t  available_write,
  input  cgra_data_pkg::ch_mask_t  available_pop,
  input  cgra_data_pkg::ch_mask_t  available_push,
  input  cgra_data_pkg::ch_mask_t  read_fifo_done,
  input  cgra_data_pkg::ch_mask_t  write_fifo_done,
  output logic [`CGRA_NUM_PE-1:0]  en_pe,
  output logic [`CGRA_NUM_CH-1:0]  en_net,
  output logic                     en_fetch,
  output logic                     done
);

  localparam int npe  = `CGRA_NUM_PE;
  localparam int n_en = `CGRA_NUM_PE + `CGRA_NUM_CH;

  typedef enum logic [1:0] {
    st_idle, st_wait_data, st_process, st_done
  } state_t;

  state_t                  state;
  logic                    avail_q;
  cgra_data_pkg::ch_mask_t en_read;
  cgra_data_pkg::ch_mask_t en_write;
  logic                    run_q;
  logic [n_en-1:0]         en_step;

  always_ff @(posedge clk) begin
    if (rst) begin
      avail_q <= 1'b0;
    end else begin
      avail_q <= (&(available_pop | ~read_mask)) & (&(available_push | ~write_mask));
    end
  end

  // --------------------------------------------------
  // step enable pipeline, one copy per load
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      en_read  <= '0;
      en_write <= '0;
      run_q    <= 1'b0;
      en_step  <= '0;
      en_pe    <= '0;
      en_net   <= '0;
    end else begin
      en_read  <= available_read | read_fifo_done;   // done lanes keep the drain going.
      en_write <= available_write | write_fifo_done;
      run_q    <= (state == st_process);
      en_step  <= {n_en{(&(en_read | ~read_mask)) & (&(en_write | ~write_mask)) & run_q}};
      en_pe    <= en_step[npe-1:0];
      en_net   <= en_step[n_en-1:npe];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      en_fetch <= 1'b0;
      done     <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_wait_data;
          end
        end
        st_wait_data: begin
          if (avail_q) begin
            state    <= st_process;
            en_fetch <= 1'b1;  // pops only while steps are issued.
          end
        end
        st_process: begin
          if (&(write_fifo_done | ~write_mask)) begin
            state    <= st_done;
            en_fetch <= 1'b0;
            done     <= 1'b1;
          end
        end
        st_done: begin
          if (start) begin
            state <= st_wait_data;
            done  <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: verilog/stream_reader.sv
`timescale 1ns/1ps
`include "cgra_defs.svh"

module stream_reader (
  input  logic                    clk,
  input  logic                    rst,
  input  cgra_data_pkg::ch_mask_t in_push,
  input  cgra_data_pkg::data_t    in_data [`CGRA_NUM_CH],
  output cgra_data_pkg::ch_mask_t in_full,
  input  logic                    en_fetch,
  input  cgra_data_pkg::ch_mask_t read_mask,
  input  logic [`CGRA_LEN_W-1:0]  stream_len,
  input  cgra_data_pkg::ch_mask_t write_ready,
  input  logic                    start,
  output cgra_data_pkg::ch_mask_t available_pop,
  output cgra_data_pkg::ch_mask_t available_read,
  output cgra_data_pkg::ch_mask_t read_fifo_done,
  output cgra_data_pkg::token_t   rd_token [`CGRA_NUM_CH]
);

  localparam int nch = `CGRA_NUM_CH;
  localparam int dly = 3;  // pop capture, then two delay stages.

  cgra_data_pkg::data_t    head [nch];
  cgra_data_pkg::ch_mask_t empty;
  cgra_data_pkg::ch_mask_t ch_pop;
  logic                    pop_all;
  logic [`CGRA_LEN_W-1:0]  rd_cnt [nch];
  cgra_data_pkg::data_t    pipe_data [dly][nch];
  cgra_data_pkg::ch_mask_t pipe_valid [dly];

  // all enabled lanes move together or not at all.
  assign pop_all = en_fetch & ~|(read_fifo_done & read_mask)
                 & (&(~empty | ~read_mask)) & (&write_ready);
  assign ch_pop         = {nch{pop_all}} & read_mask;
  assign available_pop  = ~empty;
  assign available_read = ch_pop;

  for (genvar c = 0; c < nch; c++) begin : g_ch
    stream_fifo #(
      .payload_t (cgra_data_pkg::data_t),
      .depth     (`CGRA_FIFO_DEPTH)
    ) u_in_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (in_push[c]),
      .push_data (in_data[c]),
      .pop       (ch_pop[c]),
      .head      (head[c]),
      .empty     (empty[c]),
      .full      (in_full[c]),
      .free_cnt  ()
    );

    always_ff @(posedge clk) begin
      if (rst || start) begin
        rd_cnt[c] <= '0;
      end else if (ch_pop[c]) begin
        rd_cnt[c] <= rd_cnt[c] + 1'b1;
      end
    end

    assign read_fifo_done[c] = (rd_cnt[c] == stream_len);

    // masked lane feeds a constant zero.
    assign rd_token[c] = read_mask[c] ?
                         cgra_data_pkg::token_t'{data: pipe_data[dly-1][c],
                                                 valid: pipe_valid[dly-1][c]} :
                         cgra_data_pkg::token_t'{data: '0, valid: 1'b1};
  end

  // --------------------------------------------------
  // delay to line up with the step enable
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    pipe_data[0] <= head;
    for (int k = 1; k < dly; k++) begin
      pipe_data[k] <= pipe_data[k-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < dly; k++) begin
        pipe_valid[k] <= '0;
      end
    end else begin
      pipe_valid[0] <= ch_pop;
      for (int k = 1; k < dly; k++) begin
        pipe_valid[k] <= pipe_valid[k-1];
      end
    end
  end

endmodule

// File: verilog/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         push,
  input  payload_t                     push_data,
  input  logic                         pop,
  output payload_t                     head,
  output logic                         empty,
  output logic                         full,
  output logic [$clog2(depth+1)-1:0]   free_cnt
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = $clog2(depth + 1);

  payload_t      mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [cw-1:0] count;
  logic          do_push;
  logic          do_pop;

  assign do_push  = push & ~full;  // push to a full queue is dropped.
  assign do_pop   = pop & ~empty;
  assign empty    = (count == '0);
  assign full     = (count == cw'(depth));
  assign free_cnt = cw'(depth) - count;
  assign head     = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cw'(do_push) - cw'(do_pop);
    end
  end

endmodule

// File: verilog/cgra_data_pkg.sv
`include "cgra_defs.svh"

package cgra_data_pkg;

  // --------------------------------------------------
  // data path types
  // --------------------------------------------------
  typedef logic [`CGRA_DATA_W-1:0] data_t;

  typedef logic [`CGRA_NUM_CH-1:0] ch_mask_t;  // one bit per channel.

  typedef struct packed {
    data_t data;
    logic  valid;
  } token_t;

endpackage

// File: verilog/cgra_cfg_pkg.sv
`include "cgra_defs.svh"

package cgra_cfg_pkg;

  // --------------------------------------------------
  // pe configuration
  // --------------------------------------------------
  typedef enum logic [2:0] {
    op_add     = 3'd0,
    op_sub     = 3'd1,
    op_xor     = 3'd2,
    op_mul_low = 3'd3,  // low half of the product.
    op_pass_a  = 3'd4
  } pe_op_t;

  typedef struct packed {
    pe_op_t                  op;
    logic [`CGRA_DATA_W-1:0] value;  // constant operand of stage 1.
  } pe_cfg_t;

endpackage

// File: verilog/cgra_defs.svh
`ifndef CGRA_DEFS_SVH
`define CGRA_DEFS_SVH

// --------------------------------------------------
// array geometry
// --------------------------------------------------
`define CGRA_NUM_CH 2       // read and write channels.
`define CGRA_NUM_PE 4       // two stages of two.
`define CGRA_DATA_W 16

// --------------------------------------------------
// queues and timing
// --------------------------------------------------
`define CGRA_FIFO_DEPTH 16
`define CGRA_PIPE_LAT 2     // pe stages, counted in step enables.
`define CGRA_PUSH_MARGIN 6  // words that can still land after a pop.
`define CGRA_LEN_W 8

`endif
